// ==== logic/exe_pkg.sv ====
`default_nettype none

package exe_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [15:0] half_t;

    // unit an instruction is steered to
    typedef enum logic [1:0] {
        KIND_ALU,
        KIND_MUL,
        KIND_BRANCH
    } op_kind_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_OR,
        ALU_NOR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_PASS_IMM
    } alu_op_t;

    typedef enum logic [3:0] {
        BR_JIRL,
        BR_B,
        BR_BL,
        BR_BEQ,
        BR_BNE,
        BR_BLT,
        BR_BGE,
        BR_BLTU,
        BR_BGEU
    } br_cond_t;

    // which 32 bits of the 64-bit product to return
    typedef enum logic [1:0] {
        MUL_LO,
        MUL_HI_S,
        MUL_HI_U
    } mul_sel_t;

    localparam word_t INST_BYTES = 32'd4;
    localparam int    SHAMT_W    = 5;

endpackage

`default_nettype wire

// ==== logic/alu.sv ====
`default_nettype none

module alu import exe_pkg::*; (
    input  wire alu_op_t op,
    input  wire word_t   a,
    input  wire word_t   b,
    output word_t        result
);

    logic [SHAMT_W-1:0] shamt;

    assign shamt = b[SHAMT_W-1:0];

    always_comb begin
        case (op)
            ALU_ADD:      result = a + b;
            ALU_SUB:      result = a - b;
            ALU_SLT:      result = {31'b0, $signed(a) < $signed(b)};
            ALU_SLTU:     result = {31'b0, a < b};
            ALU_AND:      result = a & b;
            ALU_OR:       result = a | b;
            ALU_NOR:      result = ~(a | b);
            ALU_XOR:      result = a ^ b;
            ALU_SLL:      result = a << shamt;
            ALU_SRL:      result = a >> shamt;
            ALU_SRA:      result = word_t'($signed(a) >>> shamt);
            // lui-style ops, the immediate arrives already shifted
            ALU_PASS_IMM: result = b;
            default:      result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/branch_unit.sv ====
`default_nettype none

module branch_unit import exe_pkg::*; (
    input  wire logic     en,
    input  wire br_cond_t cond,
    input  wire word_t    pc,
    input  wire word_t    pc_next,
    input  wire word_t    sr0,
    input  wire word_t    sr1,
    input  wire word_t    imm,
    output logic          taken,
    output logic          mispredict,
    output logic          link_write,
    output word_t         target,
    output word_t         correct_pc,
    output word_t         link_data
);

    logic cond_true;

    // jirl is register relative, everything else pc relative
    assign target = ((cond == BR_JIRL) ? sr0 : pc) + imm;

    always_comb begin
        case (cond)
            BR_JIRL, BR_B, BR_BL: cond_true = 1'b1;
            BR_BEQ:  cond_true = (sr0 == sr1);
            BR_BNE:  cond_true = (sr0 != sr1);
            BR_BLT:  cond_true = ($signed(sr0) < $signed(sr1));
            BR_BGE:  cond_true = ($signed(sr0) >= $signed(sr1));
            BR_BLTU: cond_true = (sr0 < sr1);
            BR_BGEU: cond_true = (sr0 >= sr1);
            default: cond_true = 1'b0;
        endcase
    end

    assign taken      = en && cond_true;
    assign link_data  = pc + INST_BYTES;
    assign correct_pc = cond_true ? target : link_data;

    // predictor guessed a different next pc
    assign mispredict = en && (correct_pc != pc_next);

    assign link_write = en && ((cond == BR_BL) || (cond == BR_JIRL));

endmodule

`default_nettype wire

// ==== logic/mul_stage0.sv ====
`default_nettype none

module mul_stage0 import exe_pkg::*; (
    input  wire mul_sel_t sel,
    input  wire word_t    a,
    input  wire word_t    b,
    output word_t         pp_hh,
    output word_t         pp_hl,
    output word_t         pp_lh,
    output word_t         pp_ll,
    output word_t         adjust
);

    half_t a_hi;
    half_t a_lo;
    half_t b_hi;
    half_t b_lo;
    word_t adj_a;
    word_t adj_b;

    assign a_hi = a[31:16];
    assign a_lo = a[15:0];
    assign b_hi = b[31:16];
    assign b_lo = b[15:0];

    // unsigned 16x16 partial products
    assign pp_hh = a_hi * b_hi;
    assign pp_hl = a_hi * b_lo;
    assign pp_lh = a_lo * b_hi;
    assign pp_ll = a_lo * b_lo;

    // a negative operand weighs 2^32 too much in the unsigned product,
    // so the high word loses the other operand once per negative input
    assign adj_a = a[31] ? b : '0;
    assign adj_b = b[31] ? a : '0;

    assign adjust = (sel == MUL_HI_S) ? (adj_a + adj_b) : '0;

endmodule

`default_nettype wire

// ==== logic/mul_stage1.sv ====
`default_nettype none

module mul_stage1 import exe_pkg::*; (
    input  wire mul_sel_t sel,
    input  wire word_t    pp_hh,
    input  wire word_t    pp_hl,
    input  wire word_t    pp_lh,
    input  wire word_t    pp_ll,
    input  wire word_t    adjust,
    output word_t         result
);

    logic [63:0] product;
    logic [63:0] mid_terms;
    word_t       hi_word;

    // cross terms sit one half up
    assign mid_terms = ({32'b0, pp_hl} << $bits(half_t))
                     + ({32'b0, pp_lh} << $bits(half_t));

    assign product = {pp_hh, pp_ll} + mid_terms;

    // adjust is zero unless signed high
    assign hi_word = product[63:32] - adjust;

    assign result = (sel == MUL_LO) ? product[31:0] : hi_word;

endmodule

`default_nettype wire

// ==== logic/operand_forward.sv ====
`default_nettype none

module operand_forward import exe_pkg::*; (
    input  wire reg_addr_t eu0_rj,
    input  wire reg_addr_t eu0_rk,
    input  wire reg_addr_t eu1_rj,
    input  wire reg_addr_t eu1_rk,
    input  wire word_t     eu0_src_j_data,
    input  wire word_t     eu0_src_k_data,
    input  wire word_t     eu1_src_j_data,
    input  wire word_t     eu1_src_k_data,
    input  wire logic      mid_en0,
    input  wire logic      mid_en1,
    input  wire reg_addr_t mid_rd0,
    input  wire reg_addr_t mid_rd1,
    input  wire word_t     mid_data0,
    input  wire word_t     mid_data1,
    input  wire logic      out_en0,
    input  wire logic      out_en1,
    input  wire reg_addr_t out_rd0,
    input  wire reg_addr_t out_rd1,
    input  wire word_t     out_data0,
    input  wire word_t     out_data1,
    output word_t          eu0_sr0,
    output word_t          eu0_sr1,
    output word_t          eu1_sr0,
    output word_t          eu1_sr1
);

    // lane 1 is younger than lane 0 so its producer wins
    function automatic word_t pick(input reg_addr_t r, input word_t rf_data);
        word_t v;
        v = rf_data;
        if (r != '0) begin
            if (mid_en1 && mid_rd1 == r) begin
                v = mid_data1;
            end else if (mid_en0 && mid_rd0 == r) begin
                v = mid_data0;
            end else if (out_en1 && out_rd1 == r) begin
                v = out_data1;
            end else if (out_en0 && out_rd0 == r) begin
                v = out_data0;
            end
        end
        return v;
    endfunction

    always_comb begin
        eu0_sr0 = pick(eu0_rj, eu0_src_j_data);
        eu0_sr1 = pick(eu0_rk, eu0_src_k_data);
        eu1_sr0 = pick(eu1_rj, eu1_src_j_data);
        eu1_sr1 = pick(eu1_rk, eu1_src_k_data);
    end

endmodule

`default_nettype wire

// ==== logic/exe.sv ====
`default_nettype none

module exe import exe_pkg::*; (
    input  wire logic      clk,
    input  wire logic      rst,

    input  wire logic      eu0_valid,
    input  wire op_kind_t  eu0_kind,
    input  wire reg_addr_t eu0_rd,
    input  wire reg_addr_t eu0_rj,
    input  wire reg_addr_t eu0_rk,
    input  wire word_t     eu0_imm,
    input  wire alu_op_t   eu0_alu_op,
    input  wire logic      eu0_use_imm,
    input  wire br_cond_t  eu0_br_cond,
    input  wire mul_sel_t  eu0_mul_sel,
    input  wire word_t     eu0_pc,
    input  wire word_t     eu0_pc_next,
    input  wire word_t     eu0_src_j_data,
    input  wire word_t     eu0_src_k_data,

    input  wire logic      eu1_valid,
    input  wire reg_addr_t eu1_rd,
    input  wire reg_addr_t eu1_rj,
    input  wire reg_addr_t eu1_rk,
    input  wire word_t     eu1_imm,
    input  wire alu_op_t   eu1_alu_op,
    input  wire logic      eu1_use_imm,
    input  wire word_t     eu1_src_j_data,
    input  wire word_t     eu1_src_k_data,

    output logic           en_out0,
    output logic           en_out1,
    output reg_addr_t      addr_out0,
    output reg_addr_t      addr_out1,
    output word_t          data_out0,
    output word_t          data_out1,

    output logic           branch_valid,
    output logic           branch_taken,
    output word_t          branch_pc,
    output logic           flush,
    output word_t          correct_pc_next
);

    logic  eu0_alu_en;
    logic  eu0_mul_en;
    logic  eu0_br_en;
    word_t eu0_sr0;
    word_t eu0_sr1;
    word_t eu1_sr0;
    word_t eu1_sr1;
    word_t eu0_alu_b;
    word_t eu1_alu_b;
    word_t alu0_result;
    word_t alu1_result;

    logic  br_taken;
    logic  br_mispredict;
    logic  br_link_write;
    word_t br_correct_pc;
    word_t br_link_data;

    word_t pp_hh;
    word_t pp_hl;
    word_t pp_lh;
    word_t pp_ll;
    word_t mul_adjust;
    word_t mul_result;

    // middle stage
    logic      mid_en0;
    logic      mid_en1;
    logic      mid_mul_en;
    reg_addr_t mid_rd0;
    reg_addr_t mid_rd1;
    word_t     mid_data0;
    word_t     mid_data1;
    mul_sel_t  mid_mul_sel;
    word_t     mid_pp_hh;
    word_t     mid_pp_hl;
    word_t     mid_pp_lh;
    word_t     mid_pp_ll;
    word_t     mid_adjust;

    assign eu0_alu_en = eu0_valid && (eu0_kind == KIND_ALU);
    assign eu0_mul_en = eu0_valid && (eu0_kind == KIND_MUL);
    assign eu0_br_en  = eu0_valid && (eu0_kind == KIND_BRANCH);

    assign eu0_alu_b = eu0_use_imm ? eu0_imm : eu0_sr1;
    assign eu1_alu_b = eu1_use_imm ? eu1_imm : eu1_sr1;

    operand_forward forward_i (
        .eu0_rj         (eu0_rj),
        .eu0_rk         (eu0_rk),
        .eu1_rj         (eu1_rj),
        .eu1_rk         (eu1_rk),
        .eu0_src_j_data (eu0_src_j_data),
        .eu0_src_k_data (eu0_src_k_data),
        .eu1_src_j_data (eu1_src_j_data),
        .eu1_src_k_data (eu1_src_k_data),
        .mid_en0        (mid_en0),
        .mid_en1        (mid_en1),
        .mid_rd0        (mid_rd0),
        .mid_rd1        (mid_rd1),
        .mid_data0      (mid_data0),
        .mid_data1      (mid_data1),
        .out_en0        (en_out0),
        .out_en1        (en_out1),
        .out_rd0        (addr_out0),
        .out_rd1        (addr_out1),
        .out_data0      (data_out0),
        .out_data1      (data_out1),
        .eu0_sr0        (eu0_sr0),
        .eu0_sr1        (eu0_sr1),
        .eu1_sr0        (eu1_sr0),
        .eu1_sr1        (eu1_sr1)
    );

    alu alu_0 (
        .op     (eu0_alu_op),
        .a      (eu0_sr0),
        .b      (eu0_alu_b),
        .result (alu0_result)
    );

    alu alu_1 (
        .op     (eu1_alu_op),
        .a      (eu1_sr0),
        .b      (eu1_alu_b),
        .result (alu1_result)
    );

    branch_unit branch_i (
        .en         (eu0_br_en),
        .cond       (eu0_br_cond),
        .pc         (eu0_pc),
        .pc_next    (eu0_pc_next),
        .sr0        (eu0_sr0),
        .sr1        (eu0_sr1),
        .imm        (eu0_imm),
        .taken      (br_taken),
        .mispredict (br_mispredict),
        .link_write (br_link_write),
        .target     (),
        .correct_pc (br_correct_pc),
        .link_data  (br_link_data)
    );

    mul_stage0 mul0_i (
        .sel    (eu0_mul_sel),
        .a      (eu0_sr0),
        .b      (eu0_sr1),
        .pp_hh  (pp_hh),
        .pp_hl  (pp_hl),
        .pp_lh  (pp_lh),
        .pp_ll  (pp_ll),
        .adjust (mul_adjust)
    );

    mul_stage1 mul1_i (
        .sel    (mid_mul_sel),
        .pp_hh  (mid_pp_hh),
        .pp_hl  (mid_pp_hl),
        .pp_lh  (mid_pp_lh),
        .pp_ll  (mid_pp_ll),
        .adjust (mid_adjust),
        .result (mul_result)
    );

    // flush bubbles both middle lanes and lasts one cycle
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            mid_en0      <= 1'b0;
            mid_en1      <= 1'b0;
            mid_mul_en   <= 1'b0;
            branch_valid <= 1'b0;
            flush        <= 1'b0;
        end else begin
            mid_en0      <= (eu0_alu_en || br_link_write) && (eu0_rd != '0);
            mid_en1      <= eu1_valid && (eu1_rd != '0);
            mid_mul_en   <= eu0_mul_en && (eu0_rd != '0);
            branch_valid <= eu0_br_en;
            flush        <= br_mispredict;
        end
    end

    always_ff @(posedge clk) begin
        mid_rd0         <= eu0_rd;
        mid_data0       <= eu0_br_en ? br_link_data : alu0_result;
        mid_rd1         <= eu1_rd;
        mid_data1       <= alu1_result;
        mid_mul_sel     <= eu0_mul_sel;
        mid_pp_hh       <= pp_hh;
        mid_pp_hl       <= pp_hl;
        mid_pp_lh       <= pp_lh;
        mid_pp_ll       <= pp_ll;
        mid_adjust      <= mul_adjust;
        branch_taken    <= br_taken;
        branch_pc       <= eu0_pc;
        correct_pc_next <= br_correct_pc;
    end

    // lane 1 paired with a mispredicted branch is dropped here
    always_ff @(posedge clk) begin
        if (rst) begin
            en_out0 <= 1'b0;
            en_out1 <= 1'b0;
        end else begin
            en_out0 <= mid_en0 || mid_mul_en;
            en_out1 <= mid_en1 && !flush;
        end
    end

    always_ff @(posedge clk) begin
        addr_out0 <= mid_rd0;
        data_out0 <= mid_mul_en ? mul_result : mid_data0;
        addr_out1 <= mid_rd1;
        data_out1 <= mid_data1;
    end

    a_flush_from_branch: assert property (@(posedge clk) disable iff (rst)
        flush |-> branch_valid);

    a_no_r0_lane0: assert property (@(posedge clk) disable iff (rst)
        en_out0 |-> (addr_out0 != '0));

    a_no_r0_lane1: assert property (@(posedge clk) disable iff (rst)
        en_out1 |-> (addr_out1 != '0));

    // the lane 0 output mux picks one source only
    a_lane0_one_source: assert property (@(posedge clk) disable iff (rst)
        mid_mul_en |-> !mid_en0);

endmodule

`default_nettype wire

// ==== dv/exe_tb.sv ====
`default_nettype none

module exe_tb import exe_pkg::*; ();

    localparam int NUM_INSTS      = 2000;
    localparam int RESET_CYCLES   = 4;
    localparam int DRAIN_CYCLES   = 4;
    localparam int TIMEOUT_CYCLES = NUM_INSTS + 20;

    logic      clk;
    logic      rst;
    logic      eu0_valid;
    op_kind_t  eu0_kind;
    reg_addr_t eu0_rd;
    reg_addr_t eu0_rj;
    reg_addr_t eu0_rk;
    word_t     eu0_imm;
    alu_op_t   eu0_alu_op;
    logic      eu0_use_imm;
    br_cond_t  eu0_br_cond;
    mul_sel_t  eu0_mul_sel;
    word_t     eu0_pc;
    word_t     eu0_pc_next;
    word_t     eu0_src_j_data;
    word_t     eu0_src_k_data;
    logic      eu1_valid;
    reg_addr_t eu1_rd;
    reg_addr_t eu1_rj;
    reg_addr_t eu1_rk;
    word_t     eu1_imm;
    alu_op_t   eu1_alu_op;
    logic      eu1_use_imm;
    word_t     eu1_src_j_data;
    word_t     eu1_src_k_data;

    logic      en_out0;
    logic      en_out1;
    reg_addr_t addr_out0;
    reg_addr_t addr_out1;
    word_t     data_out0;
    word_t     data_out1;
    logic      branch_valid;
    logic      branch_taken;
    word_t     branch_pc;
    logic      flush;
    word_t     correct_pc_next;

    // arch_rf in program order and rf as written back
    word_t     arch_rf [32];
    word_t     rf [32];
    logic      m_mid_en0;
    logic      m_mid_en1;
    reg_addr_t m_mid_rd0;
    reg_addr_t m_mid_rd1;
    word_t     m_mid_d0;
    word_t     m_mid_d1;
    logic      m_out_en0;
    logic      m_out_en1;
    reg_addr_t m_out_rd0;
    reg_addr_t m_out_rd1;
    word_t     m_out_d0;
    word_t     m_out_d1;
    logic      m_br_valid;
    logic      m_br_taken;
    word_t     m_br_pc;
    word_t     m_br_cpc;
    logic      m_flush;

    reg_addr_t   last_mul_rd;
    logic [31:0] rng = 32'd75594;
    int          cycle_count = 0;
    int          word_errors = 0;
    int          addr_errors = 0;
    int          bit_errors  = 0;
    int          flush_count = 0;

    exe exe_i (
        .clk             (clk),
        .rst             (rst),
        .eu0_valid       (eu0_valid),
        .eu0_kind        (eu0_kind),
        .eu0_rd          (eu0_rd),
        .eu0_rj          (eu0_rj),
        .eu0_rk          (eu0_rk),
        .eu0_imm         (eu0_imm),
        .eu0_alu_op      (eu0_alu_op),
        .eu0_use_imm     (eu0_use_imm),
        .eu0_br_cond     (eu0_br_cond),
        .eu0_mul_sel     (eu0_mul_sel),
        .eu0_pc          (eu0_pc),
        .eu0_pc_next     (eu0_pc_next),
        .eu0_src_j_data  (eu0_src_j_data),
        .eu0_src_k_data  (eu0_src_k_data),
        .eu1_valid       (eu1_valid),
        .eu1_rd          (eu1_rd),
        .eu1_rj          (eu1_rj),
        .eu1_rk          (eu1_rk),
        .eu1_imm         (eu1_imm),
        .eu1_alu_op      (eu1_alu_op),
        .eu1_use_imm     (eu1_use_imm),
        .eu1_src_j_data  (eu1_src_j_data),
        .eu1_src_k_data  (eu1_src_k_data),
        .en_out0         (en_out0),
        .en_out1         (en_out1),
        .addr_out0       (addr_out0),
        .addr_out1       (addr_out1),
        .data_out0       (data_out0),
        .data_out1       (data_out1),
        .branch_valid    (branch_valid),
        .branch_taken    (branch_taken),
        .branch_pc       (branch_pc),
        .flush           (flush),
        .correct_pc_next (correct_pc_next)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // small register window so bypasses are frequent
    function automatic reg_addr_t draw_reg();
        logic [31:0] r;
        r = next_rand();
        return reg_addr_t'(r[2:0]);
    endfunction

    function automatic reg_addr_t draw_src(input reg_addr_t avoid_a, input reg_addr_t avoid_b);
        reg_addr_t r;
        r = draw_reg();
        while (r != '0 && (r == avoid_a || r == avoid_b)) begin
            r = draw_reg();
        end
        return r;
    endfunction

    function automatic word_t alu_ref(input alu_op_t op, input word_t a, input word_t b);
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_NOR:  return ~(a | b);
            ALU_XOR:  return a ^ b;
            ALU_SLL:  return a << b[4:0];
            ALU_SRL:  return a >> b[4:0];
            ALU_SRA:  return $unsigned($signed(a) >>> b[4:0]);
            default:  return b;
        endcase
    endfunction

    function automatic logic cond_ref(input br_cond_t cond, input word_t a, input word_t b);
        case (cond)
            BR_BEQ:  return a == b;
            BR_BNE:  return a != b;
            BR_BLT:  return $signed(a) < $signed(b);
            BR_BGE:  return $signed(a) >= $signed(b);
            BR_BLTU: return a < b;
            BR_BGEU: return a >= b;
            default: return 1'b1;
        endcase
    endfunction

    function automatic word_t next_pc_ref(input br_cond_t cond, input word_t pc,
                                          input word_t a, input word_t b, input word_t imm);
        if (!cond_ref(cond, a, b)) begin
            return pc + INST_BYTES;
        end
        return ((cond == BR_JIRL) ? a : pc) + imm;
    endfunction

    function automatic word_t mul_ref(input mul_sel_t sel, input word_t a, input word_t b);
        logic [63:0]        prod_u;
        logic signed [63:0] prod_s;
        prod_u = {32'b0, a} * {32'b0, b};
        prod_s = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
        case (sel)
            MUL_LO:   return prod_u[31:0];
            MUL_HI_S: return prod_s[63:32];
            default:  return prod_u[63:32];
        endcase
    endfunction

    task automatic check_word(input string what, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("ERROR @%0t: %s got %h expected %h", $time, what, got, exp);
            word_errors++;
        end
    endtask

    task automatic check_addr(input string what, input reg_addr_t got, input reg_addr_t exp);
        if (got !== exp) begin
            $display("ERROR @%0t: %s got %0d expected %0d", $time, what, got, exp);
            addr_errors++;
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR @%0t: %s got %b expected %b", $time, what, got, exp);
            bit_errors++;
        end
    endtask

    // one clock edge of the model on the inputs the DUT just sampled
    task automatic advance_model();
        word_t a0;
        word_t k0;
        word_t a1;
        word_t b1;
        word_t res0;
        logic  w0;
        if (m_out_en0) rf[m_out_rd0] = m_out_d0;
        if (m_out_en1) rf[m_out_rd1] = m_out_d1;
        m_out_en0 = m_mid_en0;
        m_out_rd0 = m_mid_rd0;
        m_out_d0  = m_mid_d0;
        m_out_en1 = m_mid_en1 && !m_flush;
        m_out_rd1 = m_mid_rd1;
        m_out_d1  = m_mid_d1;
        if (m_flush) begin
            m_mid_en0  = 1'b0;
            m_mid_en1  = 1'b0;
            m_br_valid = 1'b0;
            m_flush    = 1'b0;
        end else begin
            a0 = arch_rf[eu0_rj];
            k0 = arch_rf[eu0_rk];
            a1 = arch_rf[eu1_rj];
            b1 = eu1_use_imm ? eu1_imm : arch_rf[eu1_rk];
            case (eu0_kind)
                KIND_MUL: begin
                    res0 = mul_ref(eu0_mul_sel, a0, k0);
                    w0   = 1'b1;
                end
                KIND_BRANCH: begin
                    res0 = eu0_pc + INST_BYTES;
                    w0   = (eu0_br_cond == BR_BL) || (eu0_br_cond == BR_JIRL);
                end
                default: begin
                    res0 = alu_ref(eu0_alu_op, a0, eu0_use_imm ? eu0_imm : k0);
                    w0   = 1'b1;
                end
            endcase
            w0 = w0 && eu0_valid && (eu0_rd != '0);
            m_mid_en0  = w0;
            m_mid_rd0  = eu0_rd;
            m_mid_d0   = res0;
            m_mid_en1  = eu1_valid && (eu1_rd != '0);
            m_mid_rd1  = eu1_rd;
            m_mid_d1   = alu_ref(eu1_alu_op, a1, b1);
            m_br_valid = eu0_valid && (eu0_kind == KIND_BRANCH);
            m_br_taken = cond_ref(eu0_br_cond, a0, k0);
            m_br_pc    = eu0_pc;
            m_br_cpc   = next_pc_ref(eu0_br_cond, eu0_pc, a0, k0, eu0_imm);
            m_flush    = m_br_valid && (m_br_cpc != eu0_pc_next);
            if (m_flush) flush_count++;
            if (w0) arch_rf[eu0_rd] = res0;
            // lane 1 beside a mispredicted branch never retires
            if (m_mid_en1 && !m_flush) arch_rf[eu1_rd] = m_mid_d1;
        end
    endtask

    task automatic drive_next();
        logic [31:0] r;
        logic        v0;
        op_kind_t    kind;
        br_cond_t    cond;
        reg_addr_t   rd0;
        reg_addr_t   rj0;
        reg_addr_t   rk0;
        reg_addr_t   rj1;
        reg_addr_t   rk1;
        word_t       pc;
        word_t       imm0;
        word_t       pc_next;
        r    = next_rand();
        v0   = (r[7:4] != 4'd0);
        kind = (r[3:0] < 4'd8) ? KIND_ALU : ((r[3:0] < 4'd11) ? KIND_MUL : KIND_BRANCH);
        cond = br_cond_t'(r[31:16] % 9);
        rd0  = draw_reg();
        rj0  = draw_src(last_mul_rd, '0);
        rk0  = draw_src(last_mul_rd, '0);
        rj1  = draw_src(last_mul_rd, v0 ? rd0 : reg_addr_t'(0));
        rk1  = draw_src(last_mul_rd, v0 ? rd0 : reg_addr_t'(0));
        pc   = next_rand() & 32'hffff_fffc;
        imm0 = next_rand();
        pc_next = pc + INST_BYTES;
        if (kind == KIND_BRANCH) begin
            imm0    = {{16{imm0[15]}}, imm0[15:2], 2'b00};
            pc_next = next_pc_ref(cond, pc, arch_rf[rj0], arch_rf[rk0], imm0);
            // roughly a third mispredicted
            if (next_rand() % 3 == 0) pc_next = pc_next + 32'h10;
        end
        eu0_valid      <= v0;
        eu0_kind       <= kind;
        eu0_rd         <= rd0;
        eu0_rj         <= rj0;
        eu0_rk         <= rk0;
        eu0_imm        <= imm0;
        eu0_alu_op     <= alu_op_t'(next_rand() % 12);
        eu0_use_imm    <= r[12];
        eu0_br_cond    <= cond;
        eu0_mul_sel    <= mul_sel_t'(next_rand() % 3);
        eu0_pc         <= pc;
        eu0_pc_next    <= pc_next;
        eu0_src_j_data <= rf[rj0];
        eu0_src_k_data <= rf[rk0];
        eu1_valid      <= (r[11:8] < 4'd13);
        eu1_rd         <= draw_reg();
        eu1_rj         <= rj1;
        eu1_rk         <= rk1;
        eu1_imm        <= next_rand();
        eu1_alu_op     <= alu_op_t'(next_rand() % 12);
        eu1_use_imm    <= r[13];
        eu1_src_j_data <= rf[rj1];
        eu1_src_k_data <= rf[rk1];
        last_mul_rd = (v0 && kind == KIND_MUL) ? rd0 : reg_addr_t'(0);
    endtask

    task automatic drive_idle();
        eu0_valid <= 1'b0;
        eu1_valid <= 1'b0;
        last_mul_rd = '0;
    endtask

    task automatic check_outputs();
        check_bit("en_out0", en_out0, m_out_en0);
        check_bit("en_out1", en_out1, m_out_en1);
        if (m_out_en0) begin
            check_addr("addr_out0", addr_out0, m_out_rd0);
            check_word("data_out0", data_out0, m_out_d0);
        end
        if (m_out_en1) begin
            check_addr("addr_out1", addr_out1, m_out_rd1);
            check_word("data_out1", data_out1, m_out_d1);
        end
        check_bit("branch_valid", branch_valid, m_br_valid);
        check_bit("flush", flush, m_flush);
        if (m_br_valid) begin
            check_bit("branch_taken", branch_taken, m_br_taken);
            check_word("branch_pc", branch_pc, m_br_pc);
            check_word("correct_pc_next", correct_pc_next, m_br_cpc);
        end
    endtask

    initial begin
        clk            = 1'b0;
        rst            = 1'b1;
        eu0_valid      = 1'b0;
        eu0_kind       = KIND_ALU;
        eu0_rd         = '0;
        eu0_rj         = '0;
        eu0_rk         = '0;
        eu0_imm        = '0;
        eu0_alu_op     = ALU_ADD;
        eu0_use_imm    = 1'b0;
        eu0_br_cond    = BR_BEQ;
        eu0_mul_sel    = MUL_LO;
        eu0_pc         = '0;
        eu0_pc_next    = '0;
        eu0_src_j_data = '0;
        eu0_src_k_data = '0;
        eu1_valid      = 1'b0;
        eu1_rd         = '0;
        eu1_rj         = '0;
        eu1_rk         = '0;
        eu1_imm        = '0;
        eu1_alu_op     = ALU_ADD;
        eu1_use_imm    = 1'b0;
        eu1_src_j_data = '0;
        eu1_src_k_data = '0;
        m_mid_en0   = 1'b0;
        m_mid_en1   = 1'b0;
        m_out_en0   = 1'b0;
        m_out_en1   = 1'b0;
        m_br_valid  = 1'b0;
        m_flush     = 1'b0;
        last_mul_rd = '0;
        for (int i = 0; i < 32; i++) begin
            arch_rf[i] = (i == 0) ? 32'd0 : next_rand();
            rf[i]      = arch_rf[i];
        end

        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        drive_next();

        for (int cyc = 0; cyc < NUM_INSTS + DRAIN_CYCLES; cyc++) begin
            @(posedge clk);
            advance_model();
            if (cyc < NUM_INSTS - 1) begin
                drive_next();
            end else begin
                drive_idle();
            end
            @(negedge clk);
            check_outputs();
        end

        $display("errors: %0d total, %0d data, %0d address, %0d flag, over %0d flushes",
                 word_errors + addr_errors + bit_errors, word_errors, addr_errors,
                 bit_errors, flush_count);
        if (word_errors + addr_errors + bit_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
logic/exe_pkg.sv
logic/alu.sv
logic/branch_unit.sv
logic/mul_stage0.sv
logic/mul_stage1.sv
logic/operand_forward.sv
logic/exe.sv
dv/exe_tb.sv

// ==== Bender.yml ====
package:
  name: exe

sources:
  - logic/exe_pkg.sv
  - logic/alu.sv
  - logic/branch_unit.sv
  - logic/mul_stage0.sv
  - logic/mul_stage1.sv
  - logic/operand_forward.sv
  - logic/exe.sv
  - target: test
    files:
      - dv/exe_tb.sv
